// File: logic/isaPkg.sv
package isaPkg;

	// field widths of the MIPS encoding
	localparam int WORD_W = 32;
	localparam int OPCODE_W = 6;
	localparam int FUNCT_W = 6;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W = 16;

	localparam int REG_COUNT = 32;

	typedef logic [WORD_W-1:0] wordT;
	typedef logic [WORD_W-1:0] instrT;
	typedef logic [REG_ADDR_W-1:0] regAddrT;
	typedef logic [OPCODE_W-1:0] opcodeT;
	typedef logic [FUNCT_W-1:0] functT;
	typedef logic [IMM_W-1:0] immT;

	// bit positions inside an instruction word
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int IMM_LSB = 0;
	localparam int FUNCT_LSB = 0;

	// opcodes
	localparam opcodeT OP_RTYPE = 6'b000000;
	localparam opcodeT OP_ADDI = 6'b001000;
	localparam opcodeT OP_SLTI = 6'b001010;
	localparam opcodeT OP_ANDI = 6'b001100;
	localparam opcodeT OP_ORI = 6'b001101;
	localparam opcodeT OP_XORI = 6'b001110;
	localparam opcodeT OP_LUI = 6'b001111;

	// funct codes for R-type
	localparam functT FN_ADD = 6'b100000;
	localparam functT FN_ADDU = 6'b100001;
	localparam functT FN_SUB = 6'b100010;
	localparam functT FN_AND = 6'b100100;
	localparam functT FN_OR = 6'b100101;
	localparam functT FN_XOR = 6'b100110;
	localparam functT FN_NOR = 6'b100111;
	localparam functT FN_SLT = 6'b101010;

endpackage

// File: logic/laneCtrlPkg.sv
package laneCtrlPkg;

	localparam int ALU_CTRL_W = 4;
	localparam int SRCB_SEL_W = 2;

	typedef logic [ALU_CTRL_W-1:0] aluCtrlT;
	typedef logic [SRCB_SEL_W-1:0] srcBSelT;

	// alu operations
	localparam aluCtrlT ALU_ADD = 4'd0;
	localparam aluCtrlT ALU_SUB = 4'd1;
	localparam aluCtrlT ALU_AND = 4'd2;
	localparam aluCtrlT ALU_OR = 4'd3;
	localparam aluCtrlT ALU_XOR = 4'd4;
	localparam aluCtrlT ALU_NOR = 4'd5;
	localparam aluCtrlT ALU_SLT = 4'd6;

	// second operand source
	localparam srcBSelT SRCB_REG = 2'd0;
	localparam srcBSelT SRCB_SIGNEXT = 2'd1;
	localparam srcBSelT SRCB_ZEROEXT = 2'd2;

endpackage

// File: logic/regPortIf.sv
`timescale 1ns/1ps

interface regPortIf
	import isaPkg::*;
();

	// read side
	regAddrT rsAddr;
	regAddrT rtAddr;
	wordT rsData;
	wordT rtData;

	// write request of the lane
	logic writeEn;
	regAddrT writeAddr;
	wordT writeData;

	modport lane (
		output rsAddr, rtAddr, writeEn, writeAddr, writeData,
		input rsData, rtData
	);

	modport regfile (
		input rsAddr, rtAddr, writeEn, writeAddr, writeData,
		output rsData, rtData
	);

endinterface

// File: logic/issueLane.sv
`timescale 1ns/1ps

module issueLane
	import isaPkg::*, laneCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic pairValid,
	input instrT instr,
	regPortIf.lane port,
	output logic resultValid,
	output logic resultEn,
	output regAddrT resultAddr,
	output wordT resultData
);

	instrT instrQ;
	logic validQ;

	opcodeT opcode;
	functT funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	immT imm;

	aluCtrlT aluCtrl;
	srcBSelT srcBSel;
	logic regDst;
	logic luiSel;
	logic knownOp;
	logic writeEn;

	wordT signImm;
	wordT zeroImm;
	wordT padImm;
	wordT srcB;
	wordT aluOut;
	wordT execOut;
	regAddrT destAddr;

	// issue register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			validQ <= 1'b0;
			instrQ <= '0;
		end
		else
		begin
			validQ <= pairValid;
			if (pairValid)
				instrQ <= instr;
		end
	end

	assign opcode = instrQ[OPCODE_LSB +: OPCODE_W];
	assign funct = instrQ[FUNCT_LSB +: FUNCT_W];
	assign rs = instrQ[RS_LSB +: REG_ADDR_W];
	assign rt = instrQ[RT_LSB +: REG_ADDR_W];
	assign rd = instrQ[RD_LSB +: REG_ADDR_W];
	assign imm = instrQ[IMM_LSB +: IMM_W];

	// decoder, anything unlisted falls through as a no-op
	always_comb
	begin
		aluCtrl = ALU_ADD;
		srcBSel = SRCB_REG;
		regDst = 1'b0;
		luiSel = 1'b0;
		knownOp = 1'b1;
		case (opcode)
			OP_RTYPE:
			begin
				regDst = 1'b1;
				case (funct)
					FN_ADD, FN_ADDU: aluCtrl = ALU_ADD;
					FN_SUB: aluCtrl = ALU_SUB;
					FN_AND: aluCtrl = ALU_AND;
					FN_OR: aluCtrl = ALU_OR;
					FN_XOR: aluCtrl = ALU_XOR;
					FN_NOR: aluCtrl = ALU_NOR;
					FN_SLT: aluCtrl = ALU_SLT;
					default: knownOp = 1'b0;
				endcase
			end
			OP_ADDI: srcBSel = SRCB_SIGNEXT;
			OP_SLTI:
			begin
				aluCtrl = ALU_SLT;
				srcBSel = SRCB_SIGNEXT;
			end
			OP_ANDI:
			begin
				aluCtrl = ALU_AND;
				srcBSel = SRCB_ZEROEXT;
			end
			OP_ORI:
			begin
				aluCtrl = ALU_OR;
				srcBSel = SRCB_ZEROEXT;
			end
			OP_XORI:
			begin
				aluCtrl = ALU_XOR;
				srcBSel = SRCB_ZEROEXT;
			end
			OP_LUI: luiSel = 1'b1;
			default: knownOp = 1'b0;
		endcase
	end

	assign writeEn = validQ && knownOp;
	assign destAddr = regDst ? rd : rt;

	// immediate forms
	assign signImm = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
	assign zeroImm = {{(WORD_W-IMM_W){1'b0}}, imm};
	assign padImm = {imm, {(WORD_W-IMM_W){1'b0}}};

	always_comb
	begin
		case (srcBSel)
			SRCB_SIGNEXT: srcB = signImm;
			SRCB_ZEROEXT: srcB = zeroImm;
			default: srcB = port.rtData;
		endcase
	end

	// alu, slt compares signed
	always_comb
	begin
		case (aluCtrl)
			ALU_SUB: aluOut = port.rsData - srcB;
			ALU_AND: aluOut = port.rsData & srcB;
			ALU_OR: aluOut = port.rsData | srcB;
			ALU_XOR: aluOut = port.rsData ^ srcB;
			ALU_NOR: aluOut = ~(port.rsData | srcB);
			ALU_SLT: aluOut = wordT'($signed(port.rsData) < $signed(srcB));
			default: aluOut = port.rsData + srcB;
		endcase
	end

	assign execOut = luiSel ? padImm : aluOut;

	// write request goes out in the execute cycle
	assign port.rsAddr = rs;
	assign port.rtAddr = rt;
	assign port.writeEn = writeEn;
	assign port.writeAddr = destAddr;
	assign port.writeData = execOut;

	// result register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resultValid <= 1'b0;
			resultEn <= 1'b0;
			resultAddr <= '0;
			resultData <= '0;
		end
		else
		begin
			resultValid <= validQ;
			resultEn <= writeEn;
			resultAddr <= destAddr;
			resultData <= execOut;
		end
	end

endmodule

// File: logic/pairRegFile.sv
`timescale 1ns/1ps

module pairRegFile
	import isaPkg::*;
(
	input logic clk,
	input logic rst,
	regPortIf.regfile lane0,
	regPortIf.regfile lane1,
	input regAddrT dbgAddr,
	output wordT dbgData
);

	wordT regs [REG_COUNT];

	logic lane0Fwd;
	wordT lane1Rs;
	wordT lane1Rt;

	// stored value with register zero pinned to zero
	function automatic wordT readReg(input regAddrT addr, input wordT stored);
		wordT value;
		value = stored;
		if (addr == '0)
			value = '0;
		return value;
	endfunction

	assign lane0.rsData = readReg(lane0.rsAddr, regs[lane0.rsAddr]);
	assign lane0.rtData = readReg(lane0.rtAddr, regs[lane0.rtAddr]);

	// lane 1 sees lane 0's result from the same pair
	assign lane0Fwd = lane0.writeEn && (lane0.writeAddr != '0);
	assign lane1Rs = readReg(lane1.rsAddr, regs[lane1.rsAddr]);
	assign lane1Rt = readReg(lane1.rtAddr, regs[lane1.rtAddr]);

	assign lane1.rsData = (lane0Fwd && (lane0.writeAddr == lane1.rsAddr)) ?
		lane0.writeData : lane1Rs;
	assign lane1.rtData = (lane0Fwd && (lane0.writeAddr == lane1.rtAddr)) ?
		lane0.writeData : lane1Rt;

	assign dbgData = readReg(dbgAddr, regs[dbgAddr]);

	// lane 1 is later in program order so its write lands last
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (lane0.writeEn && (lane0.writeAddr != '0))
				regs[lane0.writeAddr] <= lane0.writeData;
			if (lane1.writeEn && (lane1.writeAddr != '0))
				regs[lane1.writeAddr] <= lane1.writeData;
		end
	end

endmodule

// File: logic/dualIssueCore.sv
`timescale 1ns/1ps

module dualIssueCore
	import isaPkg::*;
(
	input logic clk,
	input logic rst,
	input logic pairValid,
	input instrT instr0,
	input instrT instr1,
	output logic resultValid,
	output logic wrEn0,
	output regAddrT wrAddr0,
	output wordT wrData0,
	output logic wrEn1,
	output regAddrT wrAddr1,
	output wordT wrData1,
	input regAddrT dbgAddr,
	output wordT dbgData
);

	regPortIf lane0Port();
	regPortIf lane1Port();

	// older instruction of the pair
	issueLane lane0 (
		.clk(clk),
		.rst(rst),
		.pairValid(pairValid),
		.instr(instr0),
		.port(lane0Port.lane),
		.resultValid(resultValid),
		.resultEn(wrEn0),
		.resultAddr(wrAddr0),
		.resultData(wrData0)
	);

	// both lanes load the same valid bit, lane 0 speaks for the pair
	issueLane lane1 (
		.clk(clk),
		.rst(rst),
		.pairValid(pairValid),
		.instr(instr1),
		.port(lane1Port.lane),
		.resultValid(),
		.resultEn(wrEn1),
		.resultAddr(wrAddr1),
		.resultData(wrData1)
	);

	pairRegFile regs (
		.clk(clk),
		.rst(rst),
		.lane0(lane0Port.regfile),
		.lane1(lane1Port.regfile),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData)
	);

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic clk,
	output logic rst
);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// synchronous reset, held over ten rising edges
	initial
	begin
		rst = 1'b1;
		repeat (10)
			@(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: bench/dualIssueCoreTb.sv
`timescale 1ns/1ps

module dualIssueCoreTb
	import isaPkg::*;
();

	logic clk;
	logic rst;
	logic pairValid;
	instrT instr0;
	instrT instr1;
	logic resultValid;
	logic wrEn0;
	logic wrEn1;
	regAddrT wrAddr0;
	regAddrT wrAddr1;
	regAddrT dbgAddr;
	wordT wrData0;
	wordT wrData1;
	wordT dbgData;

	// architectural state as the ISA defines it
	wordT modelRegs [REG_COUNT];
	// {en, addr, data} of lane 0 then lane 1 for each pair in flight
	logic [75:0] expQ [$];
	// cycle on which each of those pairs is due
	int dueQ [$];
	int cycleNo;
	int passCount;
	int failCount;
	int testFails;
	string testName;

	regAddrT d0;
	regAddrT d1;
	regAddrT prevDest;
	instrT i0;
	instrT i1;
	int waited;

	clockGen clkGen (.clk(clk), .rst(rst));

	dualIssueCore uut (.*);

	task automatic compareValue(input string what, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal === expVal)
			passCount++;
		else
		begin
			failCount++;
			$display("[FAIL] %0t ns %s: %s expected %h, got %h", $time, testName, what,
				expVal, actVal);
		end
	endtask

	function automatic instrT rType(regAddrT rs, regAddrT rt, regAddrT rd, functT fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic instrT iType(opcodeT op, regAddrT rs, regAddrT rt, immT imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic regAddrT randReg();
		return regAddrT'($urandom_range(0, 31));
	endfunction

	function automatic functT randFunct();
		functT fns [8];
		fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
		return fns[3'($urandom_range(0, 7))];
	endfunction

	function automatic opcodeT randImmOp();
		opcodeT ops [6];
		ops = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		return ops[3'($urandom_range(0, 5))];
	endfunction

	function automatic instrT randR();
		return rType(randReg(), randReg(), randReg(), randFunct());
	endfunction

	function automatic instrT randI();
		return iType(randImmOp(), randReg(), randReg(), immT'($urandom));
	endfunction

	// opcode or funct outside the supported set
	function automatic instrT randUnknown();
		opcodeT op;
		functT fn;
		op = opcodeT'($urandom);
		fn = functT'($urandom);
		while (op inside {OP_RTYPE, OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
			op = opcodeT'($urandom);
		while (fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT})
			fn = functT'($urandom);
		if ($urandom_range(0, 1) == 0)
			return rType(randReg(), randReg(), randReg(), fn);
		return iType(op, randReg(), randReg(), immT'($urandom));
	endfunction

	// executes one instruction on the model and returns {en, dest, result}
	function automatic logic [37:0] applyModel(input instrT ins);
		wordT a;
		wordT b;
		wordT se;
		wordT ze;
		wordT res;
		logic en;
		regAddrT dest;
		a = modelRegs[ins[25:21]];
		b = modelRegs[ins[20:16]];
		se = {{16{ins[15]}}, ins[15:0]};
		ze = {16'h0000, ins[15:0]};
		en = 1'b1;
		dest = ins[20:16];
		res = '0;
		case (ins[31:26])
			OP_RTYPE:
			begin
				dest = ins[15:11];
				case (ins[5:0])
					FN_ADD, FN_ADDU: res = a + b;
					FN_SUB: res = a - b;
					FN_AND: res = a & b;
					FN_OR: res = a | b;
					FN_XOR: res = a ^ b;
					FN_NOR: res = ~(a | b);
					FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: en = 1'b0;
				endcase
			end
			OP_ADDI: res = a + se;
			OP_SLTI: res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
			OP_ANDI: res = a & ze;
			OP_ORI: res = a | ze;
			OP_XORI: res = a ^ ze;
			OP_LUI: res = {ins[15:0], 16'h0000};
			default: en = 1'b0;
		endcase
		// r0 stays zero
		if (en && dest != 5'd0)
			modelRegs[dest] = res;
		return {en, dest, res};
	endfunction

	task automatic compareLane(input string lane, input logic [37:0] e, input logic en,
		input regAddrT addr, input wordT data);
		compareValue({lane, " write enable"}, 32'(e[37]), 32'(en));
		if (e[37])
		begin
			compareValue({lane, " write address"}, 32'(e[36:32]), 32'(addr));
			compareValue({lane, " write data"}, e[31:0], data);
		end
	endtask

	task automatic checkOutputs();
		logic [37:0] e0;
		logic [37:0] e1;
		if (resultValid === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				failCount++;
				$display("result appeared at %0t ns in test %s with no pair in flight", $time,
					testName);
			end
			else
			begin
				{e0, e1} = expQ.pop_front();
				compareValue("result cycle", 32'(dueQ.pop_front()), 32'(cycleNo));
				compareLane("lane 0", e0, wrEn0, wrAddr0, wrData0);
				compareLane("lane 1", e1, wrEn1, wrAddr1, wrData1);
			end
		end
		else
		begin
			// an idle result register never requests a write
			compareValue("idle wrEn0", 32'd0, 32'(wrEn0));
			compareValue("idle wrEn1", 32'd0, 32'(wrEn1));
		end
	endtask

	// one cycle between two falling edges
	task automatic step(input logic v, input instrT a, input instrT b);
		logic [37:0] r0;
		logic [37:0] r1;
		checkOutputs();
		pairValid = v;
		instr0 = a;
		instr1 = b;
		if (v)
		begin
			r0 = applyModel(a);
			r1 = applyModel(b);
			expQ.push_back({r0, r1});
			dueQ.push_back(cycleNo + 2);
		end
		@(negedge clk);
		cycleNo++;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (expQ.size() != 0 && n < 8)
		begin
			step(1'b0, randR(), randR());
			n++;
		end
		if (expQ.size() != 0)
		begin
			failCount++;
			$display("timed out in test %s waiting for resultValid", testName);
			expQ.delete();
			dueQ.delete();
		end
	endtask

	task automatic checkRegs();
		for (int r = 0; r < REG_COUNT; r++)
		begin
			dbgAddr = regAddrT'(r);
			step(1'b0, '0, '0);
			compareValue($sformatf("register %0d", r), modelRegs[r], dbgData);
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testFails = failCount;
	endtask

	task automatic endTest();
		drain();
		$display("test %s finished with %0d failures", testName, failCount - testFails);
	endtask

	initial
	begin
		void'($urandom(32'h1d0be1c8));
		pairValid = 1'b0;
		instr0 = '0;
		instr1 = '0;
		dbgAddr = '0;
		cycleNo = 0;
		passCount = 0;
		failCount = 0;
		for (int r = 0; r < REG_COUNT; r++)
			modelRegs[r] = '0;
		waited = 0;
		@(negedge clk);
		while (rst !== 1'b0 && waited < 40)
		begin
			@(negedge clk);
			waited++;
		end
		if (rst !== 1'b0)
		begin
			failCount++;
			$display("reset never released");
		end
		else
		begin
			beginTest("reset");
			compareValue("resultValid", 32'd0, 32'(resultValid));
			compareValue("wrEn0", 32'd0, 32'(wrEn0));
			compareValue("wrEn1", 32'd0, 32'(wrEn1));
			checkRegs();
			endTest();

			// fills the file with sign, zero and upper-half values
			beginTest("immediate");
			repeat (40)
			begin
				if ($urandom_range(0, 3) == 0)
					step(1'b0, randR(), randR());
				else
					step(1'b1, randI(), randI());
			end
			endTest();

			beginTest("rtype");
			repeat (40)
			begin
				if ($urandom_range(0, 3) == 0)
					step(1'b0, randR(), randR());
				else
					step(1'b1, randR(), randR());
			end
			endTest();

			// lane 1 reads lane 0's dest and lane 0 reads the previous lane 1 dest
			beginTest("dependence");
			prevDest = randReg();
			repeat (30)
			begin
				d0 = regAddrT'($urandom_range(1, 31));
				d1 = regAddrT'($urandom_range(1, 31));
				i0 = rType(prevDest, randReg(), d0, randFunct());
				if ($urandom_range(0, 2) == 0)
					i1 = rType(d0, randReg(), d1, randFunct());
				else if ($urandom_range(0, 1) == 0)
					i1 = rType(randReg(), d0, d1, randFunct());
				else
					i1 = iType(randImmOp(), d0, d1, immT'($urandom));
				step(1'b1, i0, i1);
				prevDest = d1;
			end
			endTest();

			beginTest("priority");
			repeat (12)
			begin
				d0 = regAddrT'($urandom_range(1, 31));
				step(1'b1, iType(randImmOp(), randReg(), d0, immT'($urandom)),
					rType(randReg(), randReg(), d0, randFunct()));
				drain();
				dbgAddr = d0;
				step(1'b0, '0, '0);
				compareValue("same-register write", modelRegs[d0], dbgData);
			end
			// r0 writes on lane 0 next to no-ops on lane 1
			repeat (12)
				step(1'b1, rType(randReg(), randReg(), 5'd0, randFunct()), randUnknown());
			endTest();

			beginTest("final state");
			checkRegs();
			endTest();
		end
		$display("%0d checks passed, %0d failed", passCount, failCount);
		if (failCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: dualIssueCore.f
logic/isaPkg.sv
logic/laneCtrlPkg.sv
logic/regPortIf.sv
logic/issueLane.sv
logic/pairRegFile.sv
logic/dualIssueCore.sv
bench/clockGen.sv
bench/dualIssueCoreTb.sv

// File: run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module dualIssueCoreTb -f dualIssueCore.f \
	--Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0
